//--- dv/image_loader_tb.sv
// Testbench with clock, reset, random PRG, CRT and TAP images, memory and bank record model
module image_loader_tb;
	import loader_pkg::*;

	logic        clk_sys = 1'b0;
	logic        reset_n;
	logic        dl_active_i;
	logic        dl_wr_i;
	logic        slot_i;
	byte_t       dl_index_i;
	byte_t       dl_data_i;
	addr_t       dl_addr_i;
	logic        dl_wait_o;
	logic        mem_we_o;
	logic        cart_attached_o;
	logic        bank_wr_o;
	addr_t       mem_addr_o;
	addr_t       bank_raddr_o;
	byte_t       mem_data_o;
	byte_t       cart_exrom_o;
	byte_t       cart_game_o;
	byte_t       bank_type_o;
	logic [15:0] cart_id_o;
	logic [15:0] bank_num_o;
	logic [15:0] bank_laddr_o;
	logic [15:0] bank_size_o;

	integer      seed = 58045;
	logic        slot_smp;
	logic        attached_during;
	logic [15:0] crt_id;
	byte_t       crt_exrom;
	byte_t       crt_game;

	// Image under download and the expected writes and bank records
	byte_t       img[$];
	addr_t       exp_addr[$];
	byte_t       exp_data[$];
	logic [80:0] exp_bank[$];

	image_loader_top UUT (.*);

	always #20 clk_sys = ~clk_sys;

	// Bus-idle level in random bursts
	always begin
		repeat (1 + rand_below(6)) @(negedge clk_sys);
		slot_i = ~slot_i;
	end

	always @(posedge clk_sys) slot_smp <= slot_i;

	// ==============================
	// Helpers
	// ==============================

	function automatic int unsigned rand_below(input int unsigned n);
		rand_below = $unsigned($random(seed)) % n;
	endfunction

	task automatic fail_text(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopping on first error");
	endtask

	task automatic fail_value(input string name, input logic [80:0] got, input logic [80:0] exp);
		fail_text($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic tick_or_timeout(inout int waited, input string what);
		@(negedge clk_sys);
		waited++;
		if (waited > 200) fail_text({"Timeout waiting for ", what});
	endtask

	task automatic send_byte(input int ofs, input byte_t data);
		int waited;
		waited = 0;
		while (dl_wait_o) tick_or_timeout(waited, "dl_wait_o to fall before the next byte");
		dl_addr_i = addr_t'(ofs);
		dl_data_i = data;
		dl_wr_i   = 1'b1;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		// Wait rises within two cycles of a written byte
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic download(input byte_t idx);
		int waited;
		waited = 0;
		dl_index_i = idx;
		@(negedge clk_sys);
		dl_active_i = 1'b1;
		@(negedge clk_sys);
		attached_during = cart_attached_o;
		foreach (img[k]) send_byte(k, img[k]);
		while (exp_addr.size() != 0 || exp_bank.size() != 0 || dl_wait_o)
			tick_or_timeout(waited, "all expected writes and bank records");
		dl_active_i = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic check_crt_result();
		assert (!attached_during) else fail_value("cart_attached_o", attached_during, 1'b0);
		assert (cart_attached_o) else fail_value("cart_attached_o", cart_attached_o, 1'b1);
		assert (cart_id_o == crt_id) else fail_value("cart_id_o", cart_id_o, crt_id);
		assert (cart_exrom_o == crt_exrom)
			else fail_value("cart_exrom_o", cart_exrom_o, crt_exrom);
		assert (cart_game_o == crt_game) else fail_value("cart_game_o", cart_game_o, crt_game);
	endtask

	// ==============================
	// Image builders and model
	// ==============================

	task automatic build_prg();
		int    n;
		addr_t a;
		img.delete();
		n = 20 + rand_below(41);
		img.push_back(byte_t'(rand_below(256)));
		img.push_back(byte_t'(rand_below(256)));
		// Load address from the first two bytes in little endian order
		a = addr_t'({img[1], img[0]});
		for (int k = 2; k < n; k++) begin
			img.push_back(byte_t'(rand_below(256)));
			exp_addr.push_back(a + addr_t'(k - 2));
			exp_data.push_back(img[k]);
		end
	endtask

	task automatic build_tap();
		int n;
		img.delete();
		n = 16 + rand_below(25);
		for (int k = 0; k < n; k++) begin
			img.push_back(byte_t'(rand_below(256)));
			exp_addr.push_back(TAP_BASE + addr_t'(k));
			exp_data.push_back(img[k]);
		end
	endtask

	task automatic build_crt();
		int           len;
		addr_t        a;
		addr_t        mask;
		logic [127:0] hdr;
		logic [55:0]  rec;
		img.delete();
		for (int k = 0; k < CRT_OFS_PACKETS; k++) img.push_back(byte_t'(rand_below(256)));
		crt_id    = 16'(rand_below(65536));
		crt_exrom = byte_t'(rand_below(256));
		crt_game  = byte_t'(rand_below(256));
		img[CRT_OFS_ID_HI] = crt_id[15:8];
		img[CRT_OFS_ID_LO] = crt_id[7:0];
		img[CRT_OFS_EXROM] = crt_exrom;
		img[CRT_OFS_GAME]  = crt_game;
		a    = CRT_BASE;
		mask = addr_t'((1 << BANK_ALIGN_W) - 1);
		repeat (1 + rand_below(3)) begin
			len = 1 + rand_below(40);
			// Record fields type, bank, load address and size
			rec = {byte_t'(rand_below(256)), 16'(rand_below(65536)),
				16'(rand_below(65536)), 16'(rand_below(65536))};
			hdr = {32'h43484950, 32'(len + CHIP_HDR_LEN), 8'h00, rec};
			for (int i = 0; i < CHIP_HDR_LEN; i++) img.push_back(hdr[127 - 8*i -: 8]);
			a = (a + mask) & ~mask;
			exp_bank.push_back({a, rec});
			for (int i = 0; i < len; i++) begin
				img.push_back(byte_t'(rand_below(256)));
				exp_addr.push_back(a);
				exp_data.push_back(img[img.size() - 1]);
				a++;
			end
		end
	endtask

	// ==============================
	// Write and bank record monitor
	// ==============================

	always @(negedge clk_sys) begin
		if (reset_n && mem_we_o) begin
			assert (slot_smp) else fail_text("Memory write launched while slot_i was low");
			assert (exp_addr.size() != 0) else fail_text("Memory write with none expected");
			assert (mem_addr_o == exp_addr[0])
				else fail_value("mem_addr_o", mem_addr_o, exp_addr[0]);
			assert (mem_data_o == exp_data[0])
				else fail_value("mem_data_o", mem_data_o, exp_data[0]);
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
		end
		if (reset_n && bank_wr_o) begin
			assert (exp_bank.size() != 0) else fail_text("Bank record with no packet header sent");
			assert ({bank_raddr_o, bank_type_o, bank_num_o, bank_laddr_o, bank_size_o} == exp_bank[0])
				else fail_value("bank_raddr_o/bank_type_o/bank_num_o/bank_laddr_o/bank_size_o",
					{bank_raddr_o, bank_type_o, bank_num_o, bank_laddr_o, bank_size_o}, exp_bank[0]);
			void'(exp_bank.pop_front());
		end
		assert (UUT.u_chk.fail_cnt == 0) else fail_text("A bound assertion in loader_chk failed");
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_wr_i     = 1'b0;
		dl_index_i  = '0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		slot_i      = 1'b0;
		repeat (5) @(negedge clk_sys);
		reset_n = 1'b1;
		assert ({mem_we_o, dl_wait_o, bank_wr_o, cart_attached_o} == 4'b0)
			else fail_value("mem_we_o/dl_wait_o/bank_wr_o/cart_attached_o",
				{mem_we_o, dl_wait_o, bank_wr_o, cart_attached_o}, 4'b0);

		build_prg();
		download(IDX_PRG);
		assert (!cart_attached_o) else fail_value("cart_attached_o", cart_attached_o, 1'b0);

		build_crt();
		download(IDX_CRT);
		check_crt_result();

		// Flag must survive a non-cartridge download
		build_prg();
		download(IDX_PRG);
		assert (cart_attached_o) else fail_value("cart_attached_o", cart_attached_o, 1'b1);

		// A second cartridge detaches the first one while it loads
		build_crt();
		download(IDX_CRT_ALT);
		check_crt_result();

		build_tap();
		download(IDX_TAP);

		if (UUT.u_chk.fail_cnt == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			fail_text("A bound assertion in loader_chk failed");
		end
	end

endmodule

//--- dv/loader_chk.sv
// Bound checks on write strobe, slot use, bank record pulse and host wait release
module loader_chk (
	input logic clk_sys,
	input logic reset_n,
	input logic slot_i,
	input logic mem_we_i,
	input logic bank_wr_i,
	input logic dl_wait_i
);

	// Count of failed properties, polled by the testbench
	int unsigned fail_cnt = 0;

	// Write strobe is a single pulse
	we_single: assert property (@(posedge clk_sys) disable iff (!reset_n) mem_we_i |=> !mem_we_i)
		else begin
			$error("mem_we_o stayed high for more than one cycle");
			fail_cnt++;
		end

	// A write only follows a cycle where the slot was open
	we_in_slot: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_i |-> $past(slot_i))
		else begin
			$error("mem_we_o without slot_i high");
			fail_cnt++;
		end

	bank_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bank_wr_i |=> !bank_wr_i)
		else begin
			$error("bank_wr_o stayed high for more than one cycle");
			fail_cnt++;
		end

	// Host is released together with the write
	wait_release: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_i |=> !dl_wait_i)
		else begin
			$error("dl_wait_o still high after mem_we_o");
			fail_cnt++;
		end

endmodule

bind image_loader_top loader_chk u_chk (
	.clk_sys   (clk_sys),
	.reset_n   (reset_n),
	.slot_i    (slot_i),
	.mem_we_i  (mem_we_o),
	.bank_wr_i (bank_wr_o),
	.dl_wait_i (dl_wait_o)
);

//--- rtl/crt_header_parser.sv
// CRT image parser: file header fields, chip packet walk, bank records, attached flag
module crt_header_parser (
	input  logic               clk_sys,
	input  logic               reset_n,

	// Host download side
	input  logic               dl_active_i,
	input  loader_pkg::byte_t  dl_index_i,
	input  logic               dl_wr_i,
	input  loader_pkg::addr_t  dl_addr_i,
	input  loader_pkg::byte_t  dl_data_i,

	// Strobes towards address generation
	output logic               crt_start_o,
	output logic               crt_align_o,
	output logic               crt_payload_o,
	output loader_pkg::byte_t  crt_data_o,

	// File header fields
	output logic [15:0]        cart_id_o,
	output loader_pkg::byte_t  cart_exrom_o,
	output loader_pkg::byte_t  cart_game_o,

	// Bank record of the current chip packet
	output logic               bank_hdr_done_o,
	output loader_pkg::byte_t  bank_type_o,
	output logic [15:0]        bank_num_o,
	output logic [15:0]        bank_laddr_o,
	output logic [15:0]        bank_size_o,

	output logic               cart_attached_o
);
	import loader_pkg::*;

	logic        load_cart;
	logic        byte_wr;
	logic        in_packets;
	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;
	logic        old_active;

	assign load_cart  = (dl_index_i == IDX_CRT) || (dl_index_i == IDX_CRT_ALT);
	assign byte_wr    = dl_wr_i && load_cart;
	assign in_packets = dl_addr_i >= addr_t'(CRT_OFS_PACKETS);

	// ==============================
	// Packet walk
	// ==============================

	// hdr_cnt is nonzero while inside a chip packet header,
	// blk_len counts the payload bytes still to come
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			crt_start_o     <= 1'b0;
			crt_align_o     <= 1'b0;
			crt_payload_o   <= 1'b0;
			bank_hdr_done_o <= 1'b0;
			hdr_cnt         <= '0;
			blk_len         <= '0;
			old_active      <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			crt_start_o     <= 1'b0;
			crt_align_o     <= 1'b0;
			crt_payload_o   <= 1'b0;
			bank_hdr_done_o <= 1'b0;
			old_active      <= dl_active_i;

			// Detached while loading, attached once the download ends
			if (old_active != dl_active_i && load_cart) begin
				cart_attached_o <= old_active;
			end

			if (byte_wr) begin
				if (dl_addr_i == '0) begin
					crt_start_o <= 1'b1;
					hdr_cnt     <= '0;
					blk_len     <= '0;
				end else if (in_packets) begin
					if (hdr_cnt == 4'd0 && blk_len == '0) begin
						// New packet begins
						hdr_cnt     <= 4'd1;
						crt_align_o <= 1'b1;
					end else if (hdr_cnt != 4'd0) begin
						// Wraps to zero after header byte 15
						hdr_cnt <= hdr_cnt + 4'd1;
						case (hdr_cnt)
							4'd4: blk_len[31:24] <= dl_data_i;
							4'd5: blk_len[23:16] <= dl_data_i;
							4'd6: blk_len[15:8] <= dl_data_i;
							4'd7: blk_len[7:0] <= dl_data_i;
							4'd8: blk_len <= blk_len - 32'(CHIP_HDR_LEN);
							4'd15: bank_hdr_done_o <= 1'b1;
							default: ;
						endcase
					end else begin
						blk_len       <= blk_len - 32'd1;
						crt_payload_o <= 1'b1;
					end
				end
			end
		end
	end

	// ==============================
	// Header field capture
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (byte_wr) begin
			crt_data_o <= dl_data_i;

			if (dl_addr_i == addr_t'(CRT_OFS_ID_HI)) cart_id_o[15:8] <= dl_data_i;
			if (dl_addr_i == addr_t'(CRT_OFS_ID_LO)) cart_id_o[7:0] <= dl_data_i;
			if (dl_addr_i == addr_t'(CRT_OFS_EXROM)) cart_exrom_o <= dl_data_i;
			if (dl_addr_i == addr_t'(CRT_OFS_GAME)) cart_game_o <= dl_data_i;

			// Chip packet fields, all big endian
			if (in_packets && hdr_cnt != 4'd0) begin
				case (hdr_cnt)
					4'd9: bank_type_o <= dl_data_i;
					4'd10: bank_num_o[15:8] <= dl_data_i;
					4'd11: bank_num_o[7:0] <= dl_data_i;
					4'd12: bank_laddr_o[15:8] <= dl_data_i;
					4'd13: bank_laddr_o[7:0] <= dl_data_i;
					4'd14: bank_size_o[15:8] <= dl_data_i;
					4'd15: bank_size_o[7:0] <= dl_data_i;
					default: ;
				endcase
			end
		end
	end

endmodule

//--- rtl/image_loader_top.sv
// Image loader top level with CRT parser, address generator and slot writer
module image_loader_top (
	input  logic               clk_sys,
	input  logic               reset_n,

	// Host download port
	input  logic               dl_active_i,
	input  loader_pkg::byte_t  dl_index_i,
	input  logic               dl_wr_i,
	input  loader_pkg::addr_t  dl_addr_i,
	input  loader_pkg::byte_t  dl_data_i,
	output logic               dl_wait_o,

	// Memory slot and write port
	input  logic               slot_i,
	output logic               mem_we_o,
	output loader_pkg::addr_t  mem_addr_o,
	output loader_pkg::byte_t  mem_data_o,

	// Cartridge header
	output logic [15:0]        cart_id_o,
	output loader_pkg::byte_t  cart_exrom_o,
	output loader_pkg::byte_t  cart_game_o,
	output logic               cart_attached_o,

	// Bank records
	output logic               bank_wr_o,
	output loader_pkg::addr_t  bank_raddr_o,
	output loader_pkg::byte_t  bank_type_o,
	output logic [15:0]        bank_num_o,
	output logic [15:0]        bank_laddr_o,
	output logic [15:0]        bank_size_o
);
	import loader_pkg::*;

	logic  crt_start;
	logic  crt_align;
	logic  crt_payload;
	byte_t crt_data;
	logic  bank_hdr_done;

	mem_wr_if wr_bus ();

	crt_header_parser u_parser (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.crt_start_o     (crt_start),
		.crt_align_o     (crt_align),
		.crt_payload_o   (crt_payload),
		.crt_data_o      (crt_data),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.bank_hdr_done_o (bank_hdr_done),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.cart_attached_o (cart_attached_o)
	);

	load_addr_gen u_addr_gen (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.crt_start_i     (crt_start),
		.crt_align_i     (crt_align),
		.crt_payload_i   (crt_payload),
		.crt_data_i      (crt_data),
		.bank_hdr_done_i (bank_hdr_done),
		.bank_wr_o       (bank_wr_o),
		.bank_raddr_o    (bank_raddr_o),
		.wr              (wr_bus.source)
	);

	slot_writer u_slot_writer (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.slot_i     (slot_i),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o),
		.wr         (wr_bus.sink)
	);

	// Host waits while a byte is still pending
	assign dl_wait_o = wr_bus.pending;

endmodule

//--- rtl/load_addr_gen.sv
// Target address counter for PRG, TAP and CRT images, issues one write request per byte
module load_addr_gen (
	input  logic               clk_sys,
	input  logic               reset_n,

	// Host download side
	input  loader_pkg::byte_t  dl_index_i,
	input  logic               dl_wr_i,
	input  loader_pkg::addr_t  dl_addr_i,
	input  loader_pkg::byte_t  dl_data_i,

	// Strobes from the CRT parser
	input  logic               crt_start_i,
	input  logic               crt_align_i,
	input  logic               crt_payload_i,
	input  loader_pkg::byte_t  crt_data_i,
	input  logic               bank_hdr_done_i,

	// Bank record address
	output logic               bank_wr_o,
	output loader_pkg::addr_t  bank_raddr_o,

	mem_wr_if.source           wr
);
	import loader_pkg::*;

	logic  is_prg;
	logic  is_tap;
	addr_t load_addr;

	assign is_prg = dl_wr_i && (dl_index_i == IDX_PRG);
	assign is_tap = dl_wr_i && (dl_index_i == IDX_TAP);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr.req    <= 1'b0;
			bank_wr_o <= 1'b0;
			load_addr <= '0;
		end else begin
			wr.req    <= 1'b0;
			bank_wr_o <= 1'b0;

			// ==============================
			// PRG
			// ==============================
			if (is_prg) begin
				if (dl_addr_i == '0) begin
					// Low byte of the load address, upper bits cleared
					load_addr <= addr_t'(dl_data_i);
				end else if (dl_addr_i == addr_t'(1)) begin
					load_addr[15:8] <= dl_data_i;
				end else begin
					wr.req    <= 1'b1;
					wr.addr   <= load_addr;
					wr.data   <= dl_data_i;
					load_addr <= load_addr + addr_t'(1);
				end
			end

			// ==============================
			// TAP
			// ==============================
			if (is_tap) begin
				wr.req  <= 1'b1;
				wr.data <= dl_data_i;
				if (dl_addr_i == '0) begin
					wr.addr   <= TAP_BASE;
					load_addr <= TAP_BASE + addr_t'(1);
				end else begin
					wr.addr   <= load_addr;
					load_addr <= load_addr + addr_t'(1);
				end
			end

			// ==============================
			// CRT
			// ==============================
			if (crt_start_i) begin
				load_addr <= CRT_BASE;
			end

			// Round up to the next bank boundary
			if (crt_align_i && load_addr[BANK_ALIGN_W-1:0] != '0) begin
				load_addr <= {load_addr[ADDR_W-1:BANK_ALIGN_W] + 1'b1, {BANK_ALIGN_W{1'b0}}};
			end

			if (crt_payload_i) begin
				wr.req    <= 1'b1;
				wr.addr   <= load_addr;
				wr.data   <= crt_data_i;
				load_addr <= load_addr + addr_t'(1);
			end

			// Bank data starts at the aligned address
			if (bank_hdr_done_i) begin
				bank_wr_o    <= 1'b1;
				bank_raddr_o <= load_addr;
			end
		end
	end

endmodule

//--- rtl/loader_pkg.sv
// Loader package: data widths, image indices, memory bases and CRT header offsets
package loader_pkg;

	// ==============================
	// Widths and basic types
	// ==============================

	// Memory address and data widths
	localparam int ADDR_W = 25;
	localparam int BYTE_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [BYTE_W-1:0] byte_t;

	// ==============================
	// Image indices from the host
	// ==============================

	// Program image, first two bytes hold the load address
	localparam byte_t IDX_PRG = 8'h04;

	// Cartridge image, reachable through two menu entries
	localparam byte_t IDX_CRT     = 8'h05;
	localparam byte_t IDX_CRT_ALT = 8'hC0;

	// Tape image
	localparam byte_t IDX_TAP = 8'h06;

	// ==============================
	// Memory map
	// ==============================

	// Cartridge banks are stored upward from here
	localparam addr_t CRT_BASE = 25'h100000;

	// Raw tape data area
	localparam addr_t TAP_BASE = 25'h200000;

	// Bank data starts on 8 KB boundaries
	localparam int BANK_ALIGN_W = 13;

	// ==============================
	// CRT file layout
	// ==============================

	// Cartridge hardware id, big endian, then the two line levels
	localparam int CRT_OFS_ID_HI = 'h16;
	localparam int CRT_OFS_ID_LO = 'h17;
	localparam int CRT_OFS_EXROM = 'h18;
	localparam int CRT_OFS_GAME  = 'h19;

	// First CHIP packet follows the file header
	localparam int CRT_OFS_PACKETS = 'h40;

	// Packet length field counts this header too
	localparam int CHIP_HDR_LEN = 16;

endpackage

//--- rtl/mem_wr_if.sv
// Write request interface between address generation and the slot writer
interface mem_wr_if;
	import loader_pkg::*;

	// One-cycle request with its address and data
	logic  req;
	addr_t addr;
	byte_t data;

	// High while the writer holds a request that is not yet written
	logic  pending;

	modport source (
		output req,
		output addr,
		output data,
		input  pending
	);

	modport sink (
		input  req,
		input  addr,
		input  data,
		output pending
	);

endinterface

//--- rtl/slot_writer.sv
// Pending write holder: host wait level and one-cycle write in a bus-idle slot
module slot_writer (
	input  logic               clk_sys,
	input  logic               reset_n,

	// Bus-idle level from the computer core
	input  logic               slot_i,

	// Memory write port
	output logic               mem_we_o,
	output loader_pkg::addr_t  mem_addr_o,
	output loader_pkg::byte_t  mem_data_o,

	mem_wr_if.sink             wr
);
	import loader_pkg::*;

	addr_t pend_addr;
	byte_t pend_data;
	logic  slot_d;
	logic  slot_rise;

	// Only a fresh slot counts, one already open when the request came is skipped
	assign slot_rise = slot_i && !slot_d;

	// ==============================
	// Pending flag and write strobe
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_d     <= 1'b0;
			wr.pending <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			slot_d   <= slot_i;
			mem_we_o <= 1'b0;

			if (wr.pending && slot_rise) begin
				// Write goes out and the host is released together
				mem_we_o   <= 1'b1;
				wr.pending <= 1'b0;
			end else if (wr.req) begin
				wr.pending <= 1'b1;
			end
		end
	end

	// Address and data held until the write is done
	always_ff @(posedge clk_sys) begin
		if (wr.req) begin
			pend_addr <= wr.addr;
			pend_data <= wr.data;
		end
	end

	assign mem_addr_o = pend_addr;
	assign mem_data_o = pend_data;

endmodule

//--- verilog.f
rtl/loader_pkg.sv
rtl/mem_wr_if.sv
rtl/crt_header_parser.sv
rtl/load_addr_gen.sv
rtl/slot_writer.sv
rtl/image_loader_top.sv
dv/loader_chk.sv
dv/image_loader_tb.sv
